// ==== accel_axi_bridge.f ====
logic/accel_axi_bridge_pkg.sv
logic/rr_arbiter.sv
logic/tag_lookaside.sv
logic/order_fifo.sv
logic/read_channel.sv
logic/write_channel.sv
logic/accel_axi_bridge.sv
verification/accel_axi_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module accel_axi_bridge_tb -f accel_axi_bridge.f -o sim_bridge

./obj_dir/sim_bridge | tee sim.log

if grep -q "All tests passed!" sim.log; then
    exit 0
else
    exit 1
fi

// ==== verification/accel_axi_bridge_tb.sv ====
module accel_axi_bridge_tb;

    import accel_axi_bridge_pkg::*;

    localparam int N_CL      = 4;
    localparam int N_ROUNDS  = 3;
    localparam int ERR_TAG   = 10;          // Write client 2 gets SLVERR
    localparam int TIMEOUT   = 3000;

    logic clk;
    logic rst = 1'b1;

    // AXI slave side
    axi_addr_t ar;
    axi_addr_t aw;
    axi_w_t    w;
    logic      arvalid, rready, awvalid, wvalid;
    logic      arready = 1'b0;
    logic      wready  = 1'b0;
    logic      awready = 1'b0;
    axi_r_t    r       = '0;
    logic      rvalid  = 1'b0;
    axi_b_t    b       = '0;
    logic      bvalid  = 1'b0;

    // Client side
    logic [N_CL-1:0]         rd_req      = '0;
    client_req_t [N_CL-1:0]  rd_info     = '0;
    logic [N_CL-1:0]         rd_ack, rd_data_vld;
    logic [DATA_W-1:0]       rd_data;
    logic [N_CL-1:0]         rd_data_rdy = '0;
    cmpl_t [N_CL-1:0]        rd_cmpl, wr_cmpl;
    logic [N_CL-1:0]         wr_req      = '0;
    client_req_t [N_CL-1:0]  wr_info     = '0;
    logic [N_CL-1:0]         wr_ack, wr_data_rdy;
    axi_w_t [N_CL-1:0]       wr_data     = '0;
    logic [N_CL-1:0]         wr_data_vld = '0;

    logic [15:0] lfsr = 16'd87;
    logic [15:0] rnd  = '0;                 // Fresh random bits each cycle
    logic        round_go  = 1'b0;
    int          round_num = 0;
    logic [7:0]  rd_cnt [N_CL];             // Beat index per read client
    logic [7:0]  wr_cnt [N_CL];
    int          rd_done_total = 0;
    int          wr_done_total = 0;
    logic [DATA_W-1:0] rd_exp [N_CL];
    logic [N_CL-1:0]   rd_done_exp;         // Last beat of the client taken
    logic [N_CL-1:0]   wr_done_exp;         // B beat carries the client tag

    // Slave model state, indexed by tag
    logic [N_TAGS-1:0] ar_pend = '0;
    logic [ADDR_W-1:0] ar_base [N_TAGS];
    logic [LEN_W-1:0]  ar_len  [N_TAGS];
    logic [LEN_W-1:0]  ar_beat [N_TAGS];
    logic [N_TAGS-1:0] b_pend  = '0;
    logic [ID_W-1:0]   aw_q [8];            // AW ids in issue order
    logic [2:0]        aw_wr = '0;
    logic [2:0]        aw_rd = '0;
    logic [7:0]        w_cnt = '0;
    logic [1:0]        ar_hs_cnt = '0;
    logic [1:0]        aw_hs_cnt = '0;
    logic              r_busy = 1'b0;
    logic [ID_W-1:0]   r_cur  = '0;
    logic [1:0]        w_client;
    logic [DATA_W-1:0] exp_w_data;
    logic              exp_w_last;

    accel_axi_bridge #(.N_RD_CLIENTS(N_CL), .N_WR_CLIENTS(N_CL), .ORDER_DEPTH(4))
        accel_axi_bridge_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////
    // Helpers
    //////////////////////
    function automatic logic rand_bit();
        logic bit_out;
        bit_out = lfsr[0];
        lfsr = (lfsr >> 1) ^ (bit_out ? 16'hB400 : 16'h0000);   // Galois taps
        return bit_out;
    endfunction

    // Beat k of a burst at A: {A+8k, tag}
    function automatic logic [DATA_W-1:0] beat_pattern(input logic [ADDR_W-1:0] base,
                                                     input logic [7:0] beat,
                                                     input logic [ID_W-1:0] tag);
        logic [59:0] a;
        a = 60'(base) + 60'(beat) * 60'd8;
        return {a, tag};
    endfunction

    task automatic stop_on_error(input string line);
        $display("Test failures found");
        $display("%s", line);
        $fatal(1);
    endtask

    always @(posedge clk) begin
        logic [15:0] nxt;
        for (int k = 0; k < 16; k++) begin
            nxt[k] = rand_bit();            // One step per bit
        end
        rnd <= nxt;
    end

    //////////////////////
    // Client drivers
    //////////////////////
    always @(posedge clk) begin
        int rd_sum;
        int wr_sum;
        logic [7:0] nb;
        client_req_t ci;
        rd_sum = 0;
        wr_sum = 0;
        if (!rst) begin
            rd_data_rdy <= rnd[7:4];        // Random client stalls
            for (int i = 0; i < N_CL; i++) begin
                if (rd_req[i] && rd_ack[i]) rd_req[i] <= 1'b0;   // Four-phase drop
                if (wr_req[i] && wr_ack[i]) wr_req[i] <= 1'b0;
                if (rd_data_vld[i] && rd_data_rdy[i]) begin
                    rd_cnt[i] <= (rd_cnt[i] == rd_info[i].len) ? 8'd0 : rd_cnt[i] + 8'd1;
                end
                if (wr_data_vld[i] && wr_data_rdy[i]) begin
                    nb = wr_cnt[i] + 8'd1;
                    if (wr_data[i].last) begin
                        wr_data_vld[i] <= 1'b0;   // Burst sent
                    end else begin
                        wr_cnt[i]  <= nb;
                        wr_data[i] <= '{data: beat_pattern(wr_info[i].addr, nb, wr_info[i].tag),
                                        last: nb == wr_info[i].len};
                    end
                end
                if (rd_cmpl[i].done) rd_sum++;
                if (wr_cmpl[i].done) wr_sum++;
            end
            rd_done_total <= rd_done_total + rd_sum;
            wr_done_total <= wr_done_total + wr_sum;
            if (round_go) begin
                for (int i = 0; i < N_CL; i++) begin
                    rd_info[i] <= '{tag: ID_W'(i),
                                    addr: ADDR_W'(29'h100000 + round_num * 'h1000 + i * 'h100),
                                    len: LEN_W'((round_num + i) % 4 + 1)};
                    ci = '{tag: ID_W'(8 + i),
                           addr: ADDR_W'(29'h800000 + round_num * 'h1000 + i * 'h100),
                           len: LEN_W'((round_num + i) % 3)};
                    wr_info[i]     <= ci;
                    rd_cnt[i]      <= '0;
                    wr_cnt[i]      <= '0;
                    wr_data[i]     <= '{data: beat_pattern(ci.addr, 8'd0, ci.tag),
                                        last: ci.len == 8'd0};
                    wr_data_vld[i] <= 1'b1;
                end
                rd_req <= '1;               // All clients at once
                wr_req <= '1;
            end
        end
    end

    //////////////////////
    // AXI slave model
    //////////////////////
    always @(posedge clk) begin
        logic [ID_W-1:0] t;
        if (!rst) begin
            arready <= rnd[0];
            wready  <= rnd[1];
            awready <= rnd[2];
            if (arvalid && arready) begin
                ar_pend[ar.id] = 1'b1;
                ar_base[ar.id] = ar.addr;
                ar_len[ar.id]  = ar.len;
                ar_beat[ar.id] = '0;
                ar_hs_cnt <= ar_hs_cnt + 2'd1;
            end
            if (rvalid && rready) begin
                if (r.last) begin
                    ar_pend[r.id] = 1'b0;
                    r_busy = 1'b0;
                end else begin
                    ar_beat[r.id] = ar_beat[r.id] + 8'd1;
                end
            end
            if (!rvalid || rready) begin
                // Random pick among outstanding tags, so reads return out of order
                for (int k = 0; k < N_TAGS; k++) begin
                    t = ID_W'(int'(rnd[15:12]) + k);
                    if (!r_busy && rnd[8] && ar_pend[t]) begin
                        r_busy = 1'b1;
                        r_cur  = t;
                    end
                end
                rvalid <= r_busy;
                r <= '{id: r_cur, data: beat_pattern(ar_base[r_cur], ar_beat[r_cur], r_cur),
                       resp: OKAY, last: ar_beat[r_cur] == ar_len[r_cur]};
            end
            if (awvalid && awready) begin
                aw_q[aw_wr] = aw.id;
                aw_wr = aw_wr + 3'd1;
                aw_hs_cnt <= aw_hs_cnt + 2'd1;
            end
            if (wvalid && wready) begin
                w_cnt <= w.last ? 8'd0 : w_cnt + 8'd1;
                if (w.last) begin
                    b_pend[aw_q[aw_rd]] = 1'b1;
                    aw_rd = aw_rd + 3'd1;
                end
            end
            bvalid <= 1'b0;                 // Bridge always accepts B
            for (int k = 0; k < N_TAGS; k++) begin
                t = ID_W'(int'(rnd[13:10]) + k);
                if (rnd[9] && b_pend[t]) begin
                    b_pend[t] = 1'b0;
                    bvalid <= 1'b1;
                    b <= '{id: t, resp: (int'(t) == ERR_TAG) ? SLVERR : OKAY};
                    break;
                end
            end
        end
    end

    //////////////////////
    // Checks
    //////////////////////
    always_comb begin
        for (int i = 0; i < N_CL; i++) begin
            rd_exp[i] = beat_pattern(rd_info[i].addr, rd_cnt[i], rd_info[i].tag);
            rd_done_exp[i] = rd_data_vld[i] && rd_data_rdy[i] && rd_cnt[i] == rd_info[i].len;
            wr_done_exp[i] = bvalid && b.id == ID_W'(8 + i);
        end
        w_client   = aw_q[aw_rd][1:0];      // Write tags are 8 + client
        exp_w_data = beat_pattern(wr_info[w_client].addr, w_cnt, wr_info[w_client].tag);
        exp_w_last = (w_cnt == wr_info[w_client].len);
    end

    a_rr_order: assert property (@(posedge clk) disable iff (rst)
        arvalid && arready |-> ar.id == {2'b00, ar_hs_cnt})
        else stop_on_error($sformatf("ERROR ar_order expected %0d actual %0d",
            $sampled(ar_hs_cnt), $sampled(ar.id)));
    a_aw_order: assert property (@(posedge clk) disable iff (rst)
        awvalid && awready |-> aw.id == wr_info[aw_hs_cnt].tag &&
            aw.addr == wr_info[aw_hs_cnt].addr && aw.len == wr_info[aw_hs_cnt].len)
        else stop_on_error($sformatf("ERROR aw_order expected %h actual %h",
            $sampled(wr_info[aw_hs_cnt]), $sampled(aw)));
    a_no_grant_acked: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> !rd_ack[ar.id[1:0]])
        else stop_on_error("AR issued for a client whose ack is still high");
    a_w_data: assert property (@(posedge clk) disable iff (rst)
        wvalid && wready |-> w.data == exp_w_data && w.last == exp_w_last)
        else stop_on_error($sformatf("ERROR w_beat expected %h/%b actual %h/%b",
            $sampled(exp_w_data), $sampled(exp_w_last), $sampled(w.data), $sampled(w.last)));

    for (genvar i = 0; i < N_CL; i++) begin : g_client
        a_rd_data: assert property (@(posedge clk) disable iff (rst)
            rd_data_vld[i] && rd_data_rdy[i] |-> rd_data == rd_exp[i])
            else stop_on_error($sformatf("ERROR rd_data client %0d expected %h actual %h",
                i, $sampled(rd_exp[i]), $sampled(rd_data)));
        a_rd_done: assert property (@(posedge clk) disable iff (rst)
            rd_cmpl[i] == {rd_done_exp[i], 1'b0})
            else stop_on_error($sformatf("ERROR rd_done client %0d expected %b actual %b",
                i, {$sampled(rd_done_exp[i]), 1'b0}, $sampled(rd_cmpl[i])));
        // Done only for the tag owner, err only for the SLVERR tag
        a_wr_cmpl: assert property (@(posedge clk) disable iff (rst)
            wr_cmpl[i] == {wr_done_exp[i], wr_done_exp[i] && (8 + i == ERR_TAG)})
            else stop_on_error($sformatf("ERROR wr_cmpl client %0d expected %b actual %b",
                i, {$sampled(wr_done_exp[i]), $sampled(wr_done_exp[i]) && (8 + i == ERR_TAG)},
                $sampled(wr_cmpl[i])));
        // Four-phase handshake on both sides
        a_rd_ack_rise: assert property (@(posedge clk) disable iff (rst)
            $rose(rd_ack[i]) |-> $past(arvalid && arready && ar.id == 4'(i)))
            else stop_on_error($sformatf("ERROR rd_ack_rise client %0d expected 0 actual 1", i));
        a_wr_ack_rise: assert property (@(posedge clk) disable iff (rst)
            $rose(wr_ack[i]) |-> $past(awvalid && awready && aw.id == 4'(8 + i)))
            else stop_on_error($sformatf("ERROR wr_ack_rise client %0d expected 0 actual 1", i));
        a_rd_ack_hold: assert property (@(posedge clk) disable iff (rst)
            rd_ack[i] && rd_req[i] |=> rd_ack[i])
            else stop_on_error($sformatf("ERROR rd_ack_hold client %0d expected 1 actual 0", i));
        a_wr_ack_hold: assert property (@(posedge clk) disable iff (rst)
            wr_ack[i] && wr_req[i] |=> wr_ack[i])
            else stop_on_error($sformatf("ERROR wr_ack_hold client %0d expected 1 actual 0", i));
        a_rd_ack_fall: assert property (@(posedge clk) disable iff (rst)
            rd_ack[i] && !rd_req[i] |=> !rd_ack[i])
            else stop_on_error($sformatf("ERROR rd_ack_fall client %0d expected 0 actual 1", i));
        a_wr_ack_fall: assert property (@(posedge clk) disable iff (rst)
            wr_ack[i] && !wr_req[i] |=> !wr_ack[i])
            else stop_on_error($sformatf("ERROR wr_ack_fall client %0d expected 0 actual 1", i));
    end

    //////////////////////
    // Main sequence
    //////////////////////
    task automatic wait_round_done(input int target);
        int n;
        n = 0;
        while (rd_done_total < target || wr_done_total < target ||
               rd_req != '0 || wr_req != '0 || rd_ack != '0 || wr_ack != '0) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) stop_on_error("Timeout waiting for all clients to complete");
        end
    endtask

    initial begin
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int rn = 0; rn < N_ROUNDS; rn++) begin
            @(posedge clk);
            round_num <= rn;
            round_go  <= 1'b1;
            @(posedge clk);
            round_go  <= 1'b0;
            wait_round_done(N_CL * (rn + 1));
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== logic/accel_axi_bridge.sv ====
module accel_axi_bridge #(
    parameter int N_RD_CLIENTS = 4,
    parameter int N_WR_CLIENTS = 4,
    parameter int ORDER_DEPTH = 4
) (
    input  logic                                            clk,
    input  logic                                            rst,
    // AXI read side
    output accel_axi_bridge_pkg::axi_addr_t                 ar,
    output logic                                            arvalid,
    input  logic                                            arready,
    input  accel_axi_bridge_pkg::axi_r_t                    r,
    input  logic                                            rvalid,
    output logic                                            rready,
    // AXI write side, bready tied high in the slave
    output accel_axi_bridge_pkg::axi_addr_t                 aw,
    output logic                                            awvalid,
    input  logic                                            awready,
    output accel_axi_bridge_pkg::axi_w_t                    w,
    output logic                                            wvalid,
    input  logic                                            wready,
    input  accel_axi_bridge_pkg::axi_b_t                    b,
    input  logic                                            bvalid,
    // Read clients
    input  logic [N_RD_CLIENTS-1:0]                         rd_req,
    input  accel_axi_bridge_pkg::client_req_t [N_RD_CLIENTS-1:0] rd_info,
    output logic [N_RD_CLIENTS-1:0]                         rd_ack,
    output logic [accel_axi_bridge_pkg::DATA_W-1:0]         rd_data,
    output logic [N_RD_CLIENTS-1:0]                         rd_data_vld,
    input  logic [N_RD_CLIENTS-1:0]                         rd_data_rdy,
    output accel_axi_bridge_pkg::cmpl_t [N_RD_CLIENTS-1:0]  rd_cmpl,
    // Write clients
    input  logic [N_WR_CLIENTS-1:0]                         wr_req,
    input  accel_axi_bridge_pkg::client_req_t [N_WR_CLIENTS-1:0] wr_info,
    output logic [N_WR_CLIENTS-1:0]                         wr_ack,
    input  accel_axi_bridge_pkg::axi_w_t [N_WR_CLIENTS-1:0] wr_data,
    input  logic [N_WR_CLIENTS-1:0]                         wr_data_vld,
    output logic [N_WR_CLIENTS-1:0]                         wr_data_rdy,
    output accel_axi_bridge_pkg::cmpl_t [N_WR_CLIENTS-1:0]  wr_cmpl
);

    ////////////////////
    // Read path
    ////////////////////
    read_channel #(.N_RD_CLIENTS(N_RD_CLIENTS)) read_channel_i (
        .clk         (clk),
        .rst         (rst),
        .rd_req      (rd_req),
        .rd_info     (rd_info),
        .rd_ack      (rd_ack),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .rd_data     (rd_data),
        .rd_data_vld (rd_data_vld),
        .rd_data_rdy (rd_data_rdy),
        .rd_cmpl     (rd_cmpl)
    );

    ////////////////////
    // Write path
    ////////////////////
    write_channel #(
        .N_WR_CLIENTS (N_WR_CLIENTS),
        .ORDER_DEPTH  (ORDER_DEPTH)
    ) write_channel_i (
        .clk         (clk),
        .rst         (rst),
        .wr_req      (wr_req),
        .wr_info     (wr_info),
        .wr_ack      (wr_ack),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .w           (w),
        .wvalid      (wvalid),
        .wready      (wready),
        .wr_data     (wr_data),
        .wr_data_vld (wr_data_vld),
        .wr_data_rdy (wr_data_rdy),
        .b           (b),
        .bvalid      (bvalid),
        .wr_cmpl     (wr_cmpl)
    );

endmodule

// ==== logic/write_channel.sv ====
module write_channel #(
    parameter int N_WR_CLIENTS = 4,
    parameter int ORDER_DEPTH = 4
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [N_WR_CLIENTS-1:0]                         wr_req,
    input  accel_axi_bridge_pkg::client_req_t [N_WR_CLIENTS-1:0] wr_info,
    output logic [N_WR_CLIENTS-1:0]                         wr_ack,
    output accel_axi_bridge_pkg::axi_addr_t                 aw,
    output logic                                            awvalid,
    input  logic                                            awready,
    output accel_axi_bridge_pkg::axi_w_t                    w,
    output logic                                            wvalid,
    input  logic                                            wready,
    input  accel_axi_bridge_pkg::axi_w_t [N_WR_CLIENTS-1:0] wr_data,
    input  logic [N_WR_CLIENTS-1:0]                         wr_data_vld,
    output logic [N_WR_CLIENTS-1:0]                         wr_data_rdy,
    input  accel_axi_bridge_pkg::axi_b_t                    b,
    input  logic                                            bvalid,
    output accel_axi_bridge_pkg::cmpl_t [N_WR_CLIENTS-1:0]  wr_cmpl
);

    import accel_axi_bridge_pkg::*;

    localparam int CW = (N_WR_CLIENTS > 1) ? $clog2(N_WR_CLIENTS) : 1;

    logic [N_WR_CLIENTS-1:0] request;
    logic [N_WR_CLIENTS-1:0] grant_oh;
    logic                    grant_vld;
    logic [CW-1:0]           grant_idx;
    client_req_t             grantee;
    logic                    aw_hs;
    logic                    w_end;       // Burst finished on W
    logic [CW-1:0]           head;        // Client feeding W
    logic                    fifo_empty;
    logic                    fifo_full;
    logic [CW-1:0]           owner;       // Client owning bid

    ////////////////////
    // AW issue
    ////////////////////
    assign grant_oh = N_WR_CLIENTS'(grant_vld) << grant_idx;
    assign request  = wr_req & ~wr_ack & ~grant_oh;

    rr_arbiter #(.N(N_WR_CLIENTS)) rr_arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .request   (request),
        .advance   (aw_hs),
        .grant_vld (grant_vld),
        .grant_idx (grant_idx)
    );

    assign grantee = wr_info[grant_idx];
    assign awvalid = grant_vld && !fifo_full;   // Full can only clear while waiting
    assign aw      = '{id: grantee.tag, addr: grantee.addr, len: grantee.len};
    assign aw_hs   = awvalid && awready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ack <= '0;
        end else begin
            for (int i = 0; i < N_WR_CLIENTS; i++) begin
                if (aw_hs && grant_idx == CW'(i)) begin
                    wr_ack[i] <= 1'b1;
                end else if (!wr_req[i]) begin
                    wr_ack[i] <= 1'b0;
                end
            end
        end
    end

    ////////////////////
    // W ordering
    ////////////////////
    order_fifo #(.ORDER_DEPTH(ORDER_DEPTH), .N_CLIENTS(N_WR_CLIENTS)) order_fifo_i (
        .clk         (clk),
        .rst         (rst),
        .push        (aw_hs),
        .push_client (grant_idx),
        .pop         (w_end),
        .head_client (head),
        .empty       (fifo_empty),
        .full        (fifo_full)
    );

    assign w           = wr_data[head];
    assign wvalid      = !fifo_empty && wr_data_vld[head];
    assign wr_data_rdy = N_WR_CLIENTS'(!fifo_empty && wready) << head;
    assign w_end       = wvalid && wready && w.last;   // Next writer takes over

    ////////////////////
    // B steering
    ////////////////////
    tag_lookaside #(.N_CLIENTS(N_WR_CLIENTS)) tag_lookaside_i (
        .clk           (clk),
        .rst           (rst),
        .alloc         (aw_hs),
        .alloc_tag     (aw.id),
        .alloc_client  (grant_idx),
        .free          (bvalid),          // Always accepted
        .free_tag      (b.id),
        .lookup_tag    (b.id),
        .lookup_client (owner)
    );

    always_comb begin
        for (int i = 0; i < N_WR_CLIENTS; i++) begin
            wr_cmpl[i].done = bvalid && (owner == CW'(i));
            wr_cmpl[i].err  = wr_cmpl[i].done && (b.resp != OKAY);
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw));

endmodule

// ==== logic/read_channel.sv ====
module read_channel #(
    parameter int N_RD_CLIENTS = 4
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [N_RD_CLIENTS-1:0]                         rd_req,
    input  accel_axi_bridge_pkg::client_req_t [N_RD_CLIENTS-1:0] rd_info,
    output logic [N_RD_CLIENTS-1:0]                         rd_ack,
    output accel_axi_bridge_pkg::axi_addr_t                 ar,
    output logic                                            arvalid,
    input  logic                                            arready,
    input  accel_axi_bridge_pkg::axi_r_t                    r,
    input  logic                                            rvalid,
    output logic                                            rready,
    output logic [accel_axi_bridge_pkg::DATA_W-1:0]         rd_data,
    output logic [N_RD_CLIENTS-1:0]                         rd_data_vld,
    input  logic [N_RD_CLIENTS-1:0]                         rd_data_rdy,
    output accel_axi_bridge_pkg::cmpl_t [N_RD_CLIENTS-1:0]  rd_cmpl
);

    import accel_axi_bridge_pkg::*;

    localparam int CW = (N_RD_CLIENTS > 1) ? $clog2(N_RD_CLIENTS) : 1;

    logic [N_RD_CLIENTS-1:0] request;
    logic [N_RD_CLIENTS-1:0] grant_oh;
    logic                    grant_vld;
    logic [CW-1:0]           grant_idx;
    client_req_t             grantee;
    logic                    ar_hs;
    logic                    r_end;    // Last beat accepted
    logic [CW-1:0]           owner;    // Client owning rid

    ////////////////////
    // AR issue
    ////////////////////
    // Drop acked clients and the one being served
    assign grant_oh = N_RD_CLIENTS'(grant_vld) << grant_idx;
    assign request  = rd_req & ~rd_ack & ~grant_oh;

    rr_arbiter #(.N(N_RD_CLIENTS)) rr_arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .request   (request),
        .advance   (ar_hs),
        .grant_vld (grant_vld),
        .grant_idx (grant_idx)
    );

    assign grantee = rd_info[grant_idx];   // Held by the client until ack
    assign arvalid = grant_vld;
    assign ar      = '{id: grantee.tag, addr: grantee.addr, len: grantee.len};
    assign ar_hs   = arvalid && arready;

    // Four-phase ack, set after the beat, cleared a cycle after req falls
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ack <= '0;
        end else begin
            for (int i = 0; i < N_RD_CLIENTS; i++) begin
                if (ar_hs && grant_idx == CW'(i)) begin
                    rd_ack[i] <= 1'b1;
                end else if (!rd_req[i]) begin
                    rd_ack[i] <= 1'b0;
                end
            end
        end
    end

    tag_lookaside #(.N_CLIENTS(N_RD_CLIENTS)) tag_lookaside_i (
        .clk           (clk),
        .rst           (rst),
        .alloc         (ar_hs),
        .alloc_tag     (ar.id),
        .alloc_client  (grant_idx),
        .free          (r_end),
        .free_tag      (r.id),
        .lookup_tag    (r.id),
        .lookup_client (owner)
    );

    ////////////////////
    // R steering
    ////////////////////
    assign rready      = rd_data_rdy[owner];               // Owner back-pressures the bus
    assign rd_data     = r.data;                           // Broadcast, vld qualifies
    assign rd_data_vld = N_RD_CLIENTS'(rvalid) << owner;
    assign r_end       = rvalid && rready && r.last;

    always_comb begin
        for (int i = 0; i < N_RD_CLIENTS; i++) begin
            rd_cmpl[i].done = r_end && (owner == CW'(i));
            rd_cmpl[i].err  = rd_cmpl[i].done && (r.resp != OKAY);
        end
    end

    // Needs the client to hold its request until ack
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar));

endmodule

// ==== logic/order_fifo.sv ====
module order_fifo #(
    parameter int ORDER_DEPTH = 4,
    parameter int N_CLIENTS = 4,
    localparam int CW = (N_CLIENTS > 1) ? $clog2(N_CLIENTS) : 1
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          push,
    input  logic [CW-1:0] push_client,
    input  logic          pop,
    output logic [CW-1:0] head_client,
    output logic          empty,
    output logic          full
);

    localparam int PTR_W = $clog2(ORDER_DEPTH);

    logic [CW-1:0]  mem [ORDER_DEPTH];
    logic [PTR_W:0] wr_ptr;   // Extra bit tells full from empty
    logic [PTR_W:0] rd_ptr;

    ////////////////////
    // Pointers
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_client;
        end
    end

    assign head_client = mem[rd_ptr[PTR_W-1:0]];   // Oldest granted writer
    assign empty       = (wr_ptr == rd_ptr);
    assign full        = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                         (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // AW issue must respect full, W last must not outrun AW
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

// ==== logic/tag_lookaside.sv ====
module tag_lookaside #(
    parameter int N_CLIENTS = 4,
    localparam int CW = (N_CLIENTS > 1) ? $clog2(N_CLIENTS) : 1
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  alloc,         // Address handshake
    input  logic [accel_axi_bridge_pkg::ID_W-1:0] alloc_tag,
    input  logic [CW-1:0]                         alloc_client,
    input  logic                                  free,          // Transaction retired
    input  logic [accel_axi_bridge_pkg::ID_W-1:0] free_tag,
    input  logic [accel_axi_bridge_pkg::ID_W-1:0] lookup_tag,
    output logic [CW-1:0]                         lookup_client
);

    import accel_axi_bridge_pkg::*;

    logic [CW-1:0]     owner [N_TAGS];   // Client index per tag
    logic [N_TAGS-1:0] busy;             // Tag outstanding on the bus

    ////////////////////
    // Busy tracking
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (free) begin
                busy[free_tag] <= 1'b0;
            end
            if (alloc) begin
                busy[alloc_tag] <= 1'b1;
            end
        end
    end

    // Owner table, written on the address beat
    always_ff @(posedge clk) begin
        if (alloc) begin
            owner[alloc_tag] <= alloc_client;
        end
    end

    assign lookup_client = owner[lookup_tag];   // Zero-latency steering

    // Client reused a tag that is still in flight
    a_alloc_idle: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !busy[alloc_tag]);

    // Slave answered a tag nobody issued
    a_free_busy: assert property (@(posedge clk) disable iff (rst)
        free |-> busy[free_tag]);

endmodule

// ==== logic/rr_arbiter.sv ====
module rr_arbiter #(
    parameter int N = 4,
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [N-1:0]     request,
    input  logic             advance,     // Current grant consumed
    output logic             grant_vld,
    output logic [IDX_W-1:0] grant_idx    // Also the last winner when idle
);

    logic             pick_vld;
    logic [IDX_W-1:0] pick_idx;

    // Scan upward starting one past the last winner
    always_comb begin
        int idx;
        pick_vld = 1'b0;
        pick_idx = grant_idx;
        for (int k = 1; k <= N; k++) begin
            idx = (int'(grant_idx) + k) % N;
            if (!pick_vld && request[idx]) begin
                pick_vld = 1'b1;
                pick_idx = IDX_W'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_vld <= 1'b0;
            grant_idx <= IDX_W'(N - 1);   // Client 0 wins first
        end else if (advance || !grant_vld) begin
            grant_vld <= pick_vld;
            if (pick_vld) begin
                grant_idx <= pick_idx;
            end
        end
    end

    // A fresh grant must come from a bit that was pending at the pick
    a_grant_requested: assert property (@(posedge clk) disable iff (rst)
        grant_vld && ($past(advance) || !$past(grant_vld))
            |-> ((($past(request) >> grant_idx) & N'(1)) != '0));

endmodule

// ==== logic/accel_axi_bridge_pkg.sv ====
package accel_axi_bridge_pkg;

    ////////////////////
    // Bus widths
    ////////////////////
    localparam int ADDR_W = 29;          // Byte address
    localparam int DATA_W = 64;          // 8-byte beats
    localparam int ID_W   = 4;           // Client supplied tag
    localparam int LEN_W  = 8;           // Beats minus one
    localparam int N_TAGS = 2 ** ID_W;   // One table entry per tag

    // AXI response code
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    ////////////////////
    // Channel payloads
    ////////////////////
    typedef struct packed {
        logic [ID_W-1:0]   tag;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } client_req_t;

    // Shared by AR and AW
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } axi_addr_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        axi_resp_e       resp;
    } axi_b_t;

    // Per-client completion, err when resp not OKAY
    typedef struct packed {
        logic done;
        logic err;
    } cmpl_t;

endpackage
